// ==== common/coreDefs.sv ====
// Core shared definitions
package coreDefs;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 4;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regIdx_t;

    // One state per clock and five per instruction
    typedef enum logic [2:0] {
        stageUndefined = 3'd0,
        stageFetch     = 3'd1,
        stageDecode    = 3'd2,
        stageExecute   = 3'd3,
        stageMemory    = 3'd4,
        stageWriteback = 3'd5,
        stageSkip      = 3'd6,
        stageHalt      = 3'd7
    } stage_e;

    typedef enum logic [3:0] {
        classBranch,
        classLoad,
        classStore,
        classDirect,
        classDirectOr,
        classAluReg,
        classAluImm,
        classRegMove,
        classRegSwap,
        classHalt,
        classNone
    } instClass_e;

    typedef enum logic [4:0] {
        aluAdd    = 5'd0,
        aluSub    = 5'd1,
        aluAnd    = 5'd2,
        aluOr     = 5'd3,
        aluXor    = 5'd4,
        aluNot    = 5'd5,
        aluShl    = 5'd6,
        aluAsr    = 5'd7,
        aluShr    = 5'd8,
        aluRor    = 5'd9,
        aluRol    = 5'd10,
        aluAndNot = 5'd11,
        aluAdc    = 5'd16,
        aluSbc    = 5'd17
    } aluOp_e;

    // Branch condition field sits in bits 27 to 24
    typedef enum logic [3:0] {
        condAlways, condZero, condNotZero, condCarry,
        condNotCarry, condNeg, condNotNeg, condOver,
        condNotOver, condHigher, condLowerSame, condGreaterEq,
        condLess, condGreater, condLessEq, condNever
    } branchCond_e;

    typedef struct packed {
        logic carry;
        logic zero;
        logic neg;
        logic over;
    } flags_t;

endpackage

// ==== common/regPortIf.sv ====
// Register file port bundle
`timescale 1ns/1ps

interface regPortIf;

    coreDefs::regIdx_t addrA;
    coreDefs::regIdx_t addrB;
    coreDefs::word_t wDataA;
    coreDefs::word_t wDataB;
    logic writeA;
    logic writeB;
    coreDefs::word_t rDataA;
    coreDefs::word_t rDataB;

    modport decoder (output addrA, addrB);
    modport datapath (output wDataA, wDataB, writeA, writeB, input rDataA, rDataB);
    modport storage (input addrA, addrB, wDataA, wDataB, writeA, writeB,
                     output rDataA, rDataB);

endinterface

// ==== source/regFile.sv ====
// General register file
`timescale 1ns/1ps

module regFile (
    input logic iClk,
    regPortIf.storage regs
);

    coreDefs::word_t regArray [2**coreDefs::regAddrWidth];

    initial begin
        for (int i = 0; i < 2**coreDefs::regAddrWidth; i++) begin
            regArray[i] = '0;
        end
    end

    // Both ports write on the edge leaving writeback
    always @(posedge iClk) begin
        if (regs.writeA) begin
            regArray[regs.addrA] <= regs.wDataA;
        end
        if (regs.writeB) begin
            regArray[regs.addrB] <= regs.wDataB;
        end
    end

    assign regs.rDataA = regArray[regs.addrA];
    assign regs.rDataB = regArray[regs.addrB];

    // Decoder folds a self swap into a single write
    assert property (@(posedge iClk)
        !(regs.writeA && regs.writeB && (regs.addrA == regs.addrB)));

endmodule

// ==== control/stageCtrl.sv ====
// Instruction state sequencer
`timescale 1ns/1ps

module stageCtrl (
    input  logic iClk,
    input  logic reset,
    output coreDefs::stage_e stage,
    input  coreDefs::instClass_e instClass,
    input  coreDefs::branchCond_e branchCond,
    input  coreDefs::flags_t flags,
    output logic halted
);

    coreDefs::stage_e nextStage;
    logic condMet;
    logic commit;

    always_comb begin
        case (branchCond)
            coreDefs::condAlways:    condMet = 1'b1;
            coreDefs::condZero:      condMet = flags.zero;
            coreDefs::condNotZero:   condMet = !flags.zero;
            coreDefs::condCarry:     condMet = flags.carry;
            coreDefs::condNotCarry:  condMet = !flags.carry;
            coreDefs::condNeg:       condMet = flags.neg;
            coreDefs::condNotNeg:    condMet = !flags.neg;
            coreDefs::condOver:      condMet = flags.over;
            coreDefs::condNotOver:   condMet = !flags.over;
            coreDefs::condHigher:    condMet = flags.carry && !flags.zero;
            coreDefs::condLowerSame: condMet = !flags.carry || flags.zero;
            coreDefs::condGreaterEq: condMet = flags.neg == flags.over;
            coreDefs::condLess:      condMet = flags.neg != flags.over;
            coreDefs::condGreater:   condMet = !flags.zero && (flags.neg == flags.over);
            coreDefs::condLessEq:    condMet = flags.zero || (flags.neg != flags.over);
            default:                 condMet = 1'b0;
        endcase
    end

    // Only branches can fail their condition
    assign commit = (instClass != coreDefs::classBranch) || condMet;

    always_comb begin
        case (stage)
            coreDefs::stageUndefined: nextStage = coreDefs::stageFetch;
            coreDefs::stageFetch:     nextStage = coreDefs::stageDecode;
            coreDefs::stageDecode:    nextStage = coreDefs::stageExecute;
            coreDefs::stageExecute:   nextStage = coreDefs::stageMemory;
            coreDefs::stageMemory:
                nextStage = commit ? coreDefs::stageWriteback : coreDefs::stageSkip;
            coreDefs::stageWriteback:
                nextStage = (instClass == coreDefs::classHalt) ? coreDefs::stageHalt
                                                               : coreDefs::stageFetch;
            coreDefs::stageSkip:      nextStage = coreDefs::stageFetch;
            default:                  nextStage = coreDefs::stageHalt;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (reset) begin
            stage <= coreDefs::stageUndefined;
        end else begin
            stage <= nextStage;
        end
    end

    assign halted = (stage == coreDefs::stageHalt);

    assert property (@(posedge iClk) disable iff (reset)
        (stage == coreDefs::stageHalt) |=> (stage == coreDefs::stageHalt));

endmodule

// ==== control/instDecode.sv ====
// Instruction word decoder
`timescale 1ns/1ps

module instDecode (
    input  coreDefs::stage_e stage,
    input  coreDefs::word_t instWord,
    output coreDefs::instClass_e instClass,
    output coreDefs::aluOp_e aluOp,
    output coreDefs::branchCond_e branchCond,
    output coreDefs::word_t immValue,
    regPortIf.decoder regs,
    output coreDefs::regIdx_t destSel
);

    logic [4:0] aluField;
    logic aluOpValid;
    logic writePhase;
    coreDefs::regIdx_t readA;
    coreDefs::regIdx_t readB;
    coreDefs::regIdx_t writeIdxA;
    coreDefs::regIdx_t writeIdxB;

    assign aluField = instWord[24:20];
    assign aluOpValid = (aluField <= 5'd11) || (aluField == 5'd16) || (aluField == 5'd17);
    assign writePhase = (stage == coreDefs::stageWriteback);
    assign branchCond = coreDefs::branchCond_e'(instWord[27:24]);

    // Leading-one pattern picks the class
    always_comb begin
        instClass = coreDefs::classNone;
        if (instWord[31]) begin
            if (instWord[30:28] == 3'b000) begin
                instClass = coreDefs::classBranch;
            end
        end else if (instWord[30]) begin
            instClass = instWord[29] ? coreDefs::classStore : coreDefs::classLoad;
        end else if (instWord[29]) begin
            instClass = instWord[28] ? coreDefs::classDirectOr : coreDefs::classDirect;
        end else if (instWord[28]) begin
            if (aluOpValid) begin
                instClass = instWord[27] ? coreDefs::classAluImm : coreDefs::classAluReg;
            end
        end else if (instWord[27]) begin
            instClass = instWord[24] ? coreDefs::classRegSwap : coreDefs::classRegMove;
        end else if (instWord[26]) begin
            if (instWord[25:20] == 6'd2) begin
                instClass = coreDefs::classHalt;
            end
        end
    end

    // destSel bit 0 enables port A, bit 1 port B
    always_comb begin
        readA = '0;
        readB = '0;
        writeIdxA = '0;
        writeIdxB = '0;
        destSel = '0;
        aluOp = coreDefs::aluAdd;
        immValue = '0;
        case (instClass)
            coreDefs::classBranch: begin
                readA = instWord[23:20];
                immValue = {{12{instWord[19]}}, instWord[19:0]};
            end
            coreDefs::classLoad, coreDefs::classStore: begin
                readA = instWord[27:24];
                readB = instWord[23:20];
                writeIdxA = instWord[23:20];
                destSel = (instClass == coreDefs::classLoad) ? 4'b0001 : 4'b0000;
                immValue = {12'b0, instWord[19:0]};
            end
            coreDefs::classDirect, coreDefs::classDirectOr: begin
                readA = instWord[27:24];
                writeIdxA = instWord[27:24];
                destSel = 4'b0001;
                if (instClass == coreDefs::classDirectOr) begin
                    aluOp = coreDefs::aluOr;
                end
                immValue = {12'b0, instWord[19:0]} << {instWord[23:20], 1'b0};
            end
            coreDefs::classAluReg, coreDefs::classAluImm: begin
                readA = instWord[15:12];
                readB = instWord[11:8];
                writeIdxA = instWord[19:16];
                destSel = 4'b0001;
                aluOp = coreDefs::aluOp_e'(aluField);
                immValue = {24'b0, instWord[7:0]} << {instWord[11:8], 1'b0};
            end
            coreDefs::classRegMove, coreDefs::classRegSwap: begin
                readA = instWord[23:20];
                readB = instWord[19:16];
                writeIdxA = instWord[19:16];
                writeIdxB = instWord[23:20];
                // Swap of a register with itself is just a move
                if (instClass == coreDefs::classRegSwap && readA != readB) begin
                    destSel = 4'b0011;
                end else begin
                    destSel = 4'b0010;
                end
            end
            default: begin
            end
        endcase
    end

    assign regs.addrA = writePhase ? writeIdxA : readA;
    assign regs.addrB = writePhase ? writeIdxB : readB;

endmodule

// ==== datapath/alu.sv ====
// Arithmetic and logic unit
`timescale 1ns/1ps

module alu (
    input  coreDefs::word_t opA,
    input  coreDefs::word_t opB,
    input  coreDefs::aluOp_e aluOp,
    input  logic carryIn,
    output coreDefs::word_t result,
    output coreDefs::flags_t flagsOut
);

    localparam int msb = coreDefs::dataWidth - 1;

    logic [coreDefs::dataWidth:0] wide;
    logic [$clog2(coreDefs::dataWidth)-1:0] amount;
    logic [2*coreDefs::dataWidth-1:0] rorWide;
    logic [2*coreDefs::dataWidth-1:0] rolWide;
    logic isAdd;
    logic isSub;

    assign amount = opB[$clog2(coreDefs::dataWidth)-1:0];
    assign rorWide = {opA, opA} >> amount;
    assign rolWide = {opA, opA} << amount;

    always_comb begin
        case (aluOp)
            coreDefs::aluAdd:    wide = {1'b0, opA} + {1'b0, opB};
            coreDefs::aluAdc:    wide = {1'b0, opA} + {1'b0, opB} + {32'b0, carryIn};
            coreDefs::aluSub:    wide = {1'b0, opA} - {1'b0, opB};
            coreDefs::aluSbc:    wide = {1'b0, opA} - {1'b0, opB} - {32'b0, carryIn};
            coreDefs::aluAnd:    wide = {1'b0, opA & opB};
            coreDefs::aluOr:     wide = {1'b0, opA | opB};
            coreDefs::aluXor:    wide = {1'b0, opA ^ opB};
            coreDefs::aluNot:    wide = {1'b0, ~opA};
            coreDefs::aluShl:    wide = {1'b0, opA << amount};
            coreDefs::aluAsr:    wide = {1'b0, $signed(opA) >>> amount};
            coreDefs::aluShr:    wide = {1'b0, opA >> amount};
            coreDefs::aluRor:    wide = {1'b0, rorWide[msb:0]};
            coreDefs::aluRol:    wide = {1'b0, rolWide[2*coreDefs::dataWidth-1:coreDefs::dataWidth]};
            coreDefs::aluAndNot: wide = {1'b0, opA & ~opB};
            default:             wide = '0;
        endcase
    end

    assign result = wide[msb:0];
    assign isAdd = (aluOp == coreDefs::aluAdd) || (aluOp == coreDefs::aluAdc);
    assign isSub = (aluOp == coreDefs::aluSub) || (aluOp == coreDefs::aluSbc);

    // Carry is the inverted borrow for subtraction
    assign flagsOut.carry = isAdd ? wide[coreDefs::dataWidth]
                          : isSub ? !wide[coreDefs::dataWidth] : 1'b0;
    assign flagsOut.zero = (result == '0);
    assign flagsOut.neg = result[msb];
    assign flagsOut.over = (isAdd && (opA[msb] == opB[msb]) && (result[msb] != opA[msb]))
                        || (isSub && (opA[msb] != opB[msb]) && (result[msb] != opA[msb]));

endmodule

// ==== datapath/execUnit.sv ====
// Datapath registers and memory interface
`timescale 1ns/1ps

module execUnit #(
    parameter coreDefs::word_t resetVector = '0
) (
    input  logic iClk,
    input  logic reset,
    input  coreDefs::stage_e stage,
    input  coreDefs::instClass_e instClass,
    input  coreDefs::aluOp_e aluOp,
    input  coreDefs::word_t immValue,
    input  coreDefs::regIdx_t destSel,
    regPortIf.datapath regs,
    output coreDefs::word_t instWord,
    output coreDefs::flags_t flags,
    output coreDefs::word_t memAddr,
    output logic memWrite,
    output coreDefs::word_t memWData,
    input  coreDefs::word_t memRData
);

    coreDefs::word_t instPtr;
    coreDefs::word_t opA;
    coreDefs::word_t opB;
    coreDefs::word_t moveData;
    coreDefs::word_t resultReg;
    coreDefs::word_t loadData;
    coreDefs::word_t aluResult;
    coreDefs::flags_t aluFlags;
    logic useImm;
    logic isMemAccess;
    logic isAluClass;

    assign useImm = (instClass == coreDefs::classBranch) || (instClass == coreDefs::classLoad)
                 || (instClass == coreDefs::classStore) || (instClass == coreDefs::classDirect)
                 || (instClass == coreDefs::classDirectOr)
                 || (instClass == coreDefs::classAluImm);
    assign isMemAccess = (instClass == coreDefs::classLoad)
                      || (instClass == coreDefs::classStore);
    assign isAluClass = (instClass == coreDefs::classAluReg)
                     || (instClass == coreDefs::classAluImm);

    alu aluInst (
        .opA(opA),
        .opB(opB),
        .aluOp(aluOp),
        .carryIn(flags.carry),
        .result(aluResult),
        .flagsOut(aluFlags)
    );

    always_ff @(posedge iClk) begin
        if (reset) begin
            instPtr <= resetVector;
            instWord <= '0;
            flags <= '0;
        end else begin
            if (stage == coreDefs::stageFetch) begin
                instWord <= memRData;
            end
            if (stage == coreDefs::stageExecute && isAluClass) begin
                flags <= aluFlags;
            end
            // Reaching writeback means a branch was taken
            if (stage == coreDefs::stageWriteback && instClass == coreDefs::classBranch) begin
                instPtr <= resultReg;
            end else if (stage == coreDefs::stageWriteback || stage == coreDefs::stageSkip) begin
                instPtr <= instPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge iClk) begin
        if (stage == coreDefs::stageDecode) begin
            // Plain direct passes the value through the adder
            opA <= (instClass == coreDefs::classDirect) ? '0 : regs.rDataA;
            opB <= useImm ? immValue : regs.rDataB;
            moveData <= regs.rDataB;
        end
        if (stage == coreDefs::stageExecute) begin
            resultReg <= aluResult;
        end
        if (stage == coreDefs::stageMemory) begin
            loadData <= memRData;
        end
    end

    assign memAddr = (stage == coreDefs::stageFetch) ? instPtr
                   : (stage == coreDefs::stageMemory && isMemAccess) ? resultReg : '0;
    assign memWrite = (stage == coreDefs::stageMemory) && (instClass == coreDefs::classStore);
    assign memWData = moveData;

    // Port A carries results, port B the moved source
    assign regs.wDataA = (instClass == coreDefs::classRegSwap) ? opA
                       : (instClass == coreDefs::classLoad) ? loadData : resultReg;
    assign regs.wDataB = moveData;
    assign regs.writeA = (stage == coreDefs::stageWriteback) && destSel[0];
    assign regs.writeB = (stage == coreDefs::stageWriteback) && destSel[1];

    // Store strobe comes only right after execute
    assert property (@(posedge iClk) disable iff (reset)
        memWrite |-> (stage == coreDefs::stageMemory)
                     && ($past(stage) == coreDefs::stageExecute));

endmodule

// ==== source/epCore.sv ====
// Multi-cycle RISC core
`timescale 1ns/1ps

module epCore #(
    parameter coreDefs::word_t resetVector = '0
) (
    input  logic iClk,
    input  logic reset,
    output coreDefs::word_t memAddr,
    output logic memWrite,
    output coreDefs::word_t memWData,
    input  coreDefs::word_t memRData,
    output logic halted
);

    coreDefs::stage_e stage;
    coreDefs::instClass_e instClass;
    coreDefs::aluOp_e aluOp;
    coreDefs::branchCond_e branchCond;
    coreDefs::word_t immValue;
    coreDefs::regIdx_t destSel;
    coreDefs::word_t instWord;
    coreDefs::flags_t flags;

    regPortIf regs ();

    stageCtrl stageCtrlInst (
        .iClk(iClk),
        .reset(reset),
        .stage(stage),
        .instClass(instClass),
        .branchCond(branchCond),
        .flags(flags),
        .halted(halted)
    );

    // Stage steers the register addresses into writeback
    instDecode instDecodeInst (
        .stage(stage),
        .instWord(instWord),
        .instClass(instClass),
        .aluOp(aluOp),
        .branchCond(branchCond),
        .immValue(immValue),
        .regs(regs.decoder),
        .destSel(destSel)
    );

    execUnit #(
        .resetVector(resetVector)
    ) execUnitInst (
        .iClk(iClk),
        .reset(reset),
        .stage(stage),
        .instClass(instClass),
        .aluOp(aluOp),
        .immValue(immValue),
        .destSel(destSel),
        .regs(regs.datapath),
        .instWord(instWord),
        .flags(flags),
        .memAddr(memAddr),
        .memWrite(memWrite),
        .memWData(memWData),
        .memRData(memRData)
    );

    regFile regFileInst (
        .iClk(iClk),
        .regs(regs.storage)
    );

endmodule

// ==== verification/coreChecker.sv ====
// Instruction-set model and bus checker
`timescale 1ns/1ps

module coreChecker #(
    parameter coreDefs::word_t resetVector = '0
) (
    input  logic iClk,
    input  logic reset,
    input  coreDefs::word_t memAddr,
    input  logic memWrite,
    input  coreDefs::word_t memWData,
    input  coreDefs::word_t memRData,
    input  logic halted,
    output int errorCount,
    output logic modelHalted
);

    coreDefs::word_t modelRegs [16];
    coreDefs::word_t ip;
    coreDefs::word_t inst;
    coreDefs::flags_t flags;
    coreDefs::word_t expAddr;
    coreDefs::word_t expData;
    logic expLoad;
    logic expStore;
    logic haltPending;
    logic started;
    int phase;

    // Register file starts cleared
    initial begin
        errorCount = 0;
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
    end

    task automatic compare(input string name, input coreDefs::word_t expected,
                           input coreDefs::word_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        end
    endtask

    function automatic logic condHolds(input logic [3:0] cond, input coreDefs::flags_t f);
        case (cond)
            4'd0:    return 1'b1;
            4'd1:    return f.zero;
            4'd2:    return !f.zero;
            4'd3:    return f.carry;
            4'd4:    return !f.carry;
            4'd5:    return f.neg;
            4'd6:    return !f.neg;
            4'd7:    return f.over;
            4'd8:    return !f.over;
            4'd9:    return f.carry && !f.zero;
            4'd10:   return !f.carry || f.zero;
            4'd11:   return f.neg == f.over;
            4'd12:   return f.neg != f.over;
            4'd13:   return !f.zero && (f.neg == f.over);
            4'd14:   return f.zero || (f.neg != f.over);
            default: return 1'b0;
        endcase
    endfunction

    task automatic aluModel(input logic [4:0] op, input coreDefs::word_t a,
                            input coreDefs::word_t b, input logic cin,
                            output coreDefs::word_t r, output coreDefs::flags_t f);
        logic [32:0] wide;
        logic [33:0] exact;
        logic [4:0] n;
        logic isSum;
        logic isDiff;
        logic useCin;
        n = b[4:0];
        wide = '0;
        case (op)
            5'd0:  wide = {1'b0, a} + {1'b0, b};
            5'd16: wide = {1'b0, a} + {1'b0, b} + 33'(cin);
            5'd1:  wide = {1'b0, a} - {1'b0, b};
            5'd17: wide = {1'b0, a} - {1'b0, b} - 33'(cin);
            5'd2:  wide[31:0] = a & b;
            5'd3:  wide[31:0] = a | b;
            5'd4:  wide[31:0] = a ^ b;
            5'd5:  wide[31:0] = ~a;
            5'd6:  wide[31:0] = a << n;
            5'd7:  wide[31:0] = $signed(a) >>> n;
            5'd8:  wide[31:0] = a >> n;
            5'd9:  wide[31:0] = (a >> n) | (a << (6'd32 - n));
            5'd10: wide[31:0] = (a << n) | (a >> (6'd32 - n));
            5'd11: wide[31:0] = a & ~b;
            default: wide = '0;
        endcase
        r = wide[31:0];
        isSum = (op == 5'd0) || (op == 5'd16);
        isDiff = (op == 5'd1) || (op == 5'd17);
        useCin = ((op == 5'd16) || (op == 5'd17)) && cin;
        f.zero = (r == '0);
        f.neg = r[31];
        // Subtraction reports no-borrow as carry
        f.carry = isSum ? wide[32] : (isDiff ? ({1'b0, a} >= {1'b0, b} + 33'(useCin)) : 1'b0);
        // Signed overflow when the exact result does not fit in 32 bits
        if (isSum) begin
            exact = {{2{a[31]}}, a} + {{2{b[31]}}, b} + 34'(useCin);
        end else begin
            exact = {{2{a[31]}}, a} - {{2{b[31]}}, b} - 34'(useCin);
        end
        f.over = (isSum || isDiff) && (exact[32] != exact[31]);
    endtask

    // Executes the instruction in inst as it leaves the memory state
    task automatic stepModel();
        coreDefs::word_t a;
        coreDefs::word_t b;
        coreDefs::word_t r;
        coreDefs::word_t imm;
        coreDefs::word_t nextIp;
        coreDefs::flags_t f;
        logic [4:0] op;
        nextIp = ip + 1;
        expLoad = 1'b0;
        expStore = 1'b0;
        expAddr = '0;
        expData = '0;
        if (inst[31]) begin
            if (inst[30:28] == 3'b000 && condHolds(inst[27:24], flags)) begin
                nextIp = modelRegs[inst[23:20]] + {{12{inst[19]}}, inst[19:0]};
            end
        end else if (inst[30]) begin
            expAddr = modelRegs[inst[27:24]] + {12'b0, inst[19:0]};
            if (inst[29]) begin
                expStore = 1'b1;
                expData = modelRegs[inst[23:20]];
            end else begin
                expLoad = 1'b1;
                modelRegs[inst[23:20]] = memRData;
            end
        end else if (inst[29]) begin
            imm = {12'b0, inst[19:0]} << (2 * inst[23:20]);
            modelRegs[inst[27:24]] = inst[28] ? (modelRegs[inst[27:24]] | imm) : imm;
        end else if (inst[28]) begin
            op = inst[24:20];
            if (op <= 5'd11 || op == 5'd16 || op == 5'd17) begin
                a = modelRegs[inst[15:12]];
                b = inst[27] ? ({24'b0, inst[7:0]} << (2 * inst[11:8])) : modelRegs[inst[11:8]];
                aluModel(op, a, b, flags.carry, r, f);
                modelRegs[inst[19:16]] = r;
                flags = f;
            end
        end else if (inst[27]) begin
            a = modelRegs[inst[23:20]];
            b = modelRegs[inst[19:16]];
            modelRegs[inst[23:20]] = b;
            if (inst[24]) begin
                modelRegs[inst[19:16]] = a;
            end
        end else if (inst[26] && inst[25:20] == 6'd2) begin
            haltPending = 1'b1;
        end
        ip = nextIp;
    endtask

    always @(posedge iClk) begin
        if (reset) begin
            ip = resetVector;
            flags = '0;
            phase = 0;
            started = 1'b0;
            haltPending = 1'b0;
            modelHalted = 1'b0;
        end else if (modelHalted) begin
            compare("halted", 32'd1, {31'b0, halted});
            compare("write strobe", '0, {31'b0, memWrite});
        end else begin
            compare("halted", '0, {31'b0, halted});
            expStore = 1'b0;
            if (!started) begin
                started = 1'b1;
            end else begin
                case (phase)
                    0: begin
                        compare("fetch address", ip, memAddr);
                        inst = memRData;
                    end
                    3: begin
                        stepModel();
                        if (expLoad || expStore) begin
                            compare("data address", expAddr, memAddr);
                        end
                        if (expStore) begin
                            compare("store data", expData, memWData);
                        end
                    end
                    4: modelHalted = haltPending;
                    default: begin
                    end
                endcase
                phase = (phase == 4) ? 0 : phase + 1;
            end
            compare("write strobe", {31'b0, expStore}, {31'b0, memWrite});
        end
    end

endmodule

// ==== verification/coreTb.sv ====
// Core testbench
`timescale 1ns/1ps

module coreTb;

    localparam coreDefs::word_t resetVector = '0;
    localparam int progLen = 200;
    localparam int memWords = 1024;
    localparam int dataBase = 512;
    localparam int resetCycles = 16;
    localparam int timeoutCycles = progLen * 5 + 100;

    logic iClk;
    logic reset;
    coreDefs::word_t memAddr;
    logic memWrite;
    coreDefs::word_t memWData;
    coreDefs::word_t memRData;
    logic halted;
    logic modelHalted;
    int errorCount;
    int otherErrors;
    integer seed;
    coreDefs::word_t mem [memWords];

    epCore #(
        .resetVector(resetVector)
    ) dut (
        .iClk(iClk),
        .reset(reset),
        .memAddr(memAddr),
        .memWrite(memWrite),
        .memWData(memWData),
        .memRData(memRData),
        .halted(halted)
    );

    coreChecker #(
        .resetVector(resetVector)
    ) busCheck (
        .iClk(iClk),
        .reset(reset),
        .memAddr(memAddr),
        .memWrite(memWrite),
        .memWData(memWData),
        .memRData(memRData),
        .halted(halted),
        .errorCount(errorCount),
        .modelHalted(modelHalted)
    );

    always #2 iClk = ~iClk;

    // Memory answers mid-cycle
    always @(negedge iClk) begin
        memRData <= mem[memAddr[9:0]];
    end

    always @(posedge iClk) begin
        if (memWrite) begin
            mem[memAddr[9:0]] <= memWData;
        end
    end

    function automatic int unsigned pickBelow(int unsigned limit);
        logic [31:0] raw;
        raw = $random(seed);
        return raw % limit;
    endfunction

    // R15 stays zero as the base for branches and memory
    function automatic coreDefs::word_t randomInst(int pc);
        logic [3:0] dst;
        logic [3:0] dst2;
        logic [3:0] srcA;
        logic [3:0] srcB;
        logic [4:0] op;
        logic [19:0] value;
        int span;
        dst = 4'(pickBelow(15));
        dst2 = 4'(pickBelow(15));
        srcA = 4'(pickBelow(16));
        srcB = 4'(pickBelow(16));
        value = 20'(pickBelow(32'h10_0000));
        op = 5'(pickBelow(14));
        if (op > 5'd11) begin
            op = op + 5'd4;
        end
        span = progLen - 1 - pc;
        if (span > 8) begin
            span = 8;
        end
        case (pickBelow(12))
            0, 1, 2: return {4'b0001, 1'b0, 2'b00, op, dst, srcA, srcB, value[7:0]};
            3, 4:    return {4'b0001, 1'b1, 2'b00, op, dst, srcA, srcB, value[7:0]};
            5:       return {4'b1000, srcA, 4'd15, 20'(pc + 1 + int'(pickBelow(span)))};
            6, 7:    return {4'b0110, 4'd15, srcA, 20'(dataBase + int'(pickBelow(512)))};
            8:       return {4'b0100, 4'd15, dst, 20'(dataBase + int'(pickBelow(512)))};
            9:       return {3'b001, srcB[0], dst, 1'b0, srcA[2:0], value};
            10:      return {5'b00001, 2'b00, 1'b0, dst, srcA, 16'd0};
            default: return {5'b00001, 2'b00, 1'b1, dst, dst2, 16'd0};
        endcase
    endfunction

    task automatic buildProgram();
        for (int i = 0; i < memWords; i++) begin
            mem[i] = coreDefs::word_t'(i) * 32'h9e37_79b9 ^ 32'h0bad_f00d;
        end
        for (int i = 0; i < 15; i++) begin
            mem[i] = {4'b0010, 4'(i), 4'(pickBelow(7)), 20'(pickBelow(32'h10_0000))};
        end
        mem[15] = {4'b0010, 4'd15, 4'd0, 20'd0};
        for (int i = 16; i < progLen - 1; i++) begin
            mem[i] = randomInst(i);
        end
        mem[progLen - 1] = {6'b000001, 6'd2, 20'd0};
    endtask

    initial begin
        iClk = 1'b0;
        reset = 1'b1;
        memRData = '0;
        otherErrors = 0;
        seed = 32'h7260_dc91;
        buildProgram();
        repeat (resetCycles) @(posedge iClk);
        @(negedge iClk);
        reset = 1'b0;
        while (halted !== 1'b1) begin
            @(negedge iClk);
        end
        // Idle a while to catch stray fetches or writes
        repeat (20) @(negedge iClk);
        if (modelHalted !== 1'b1) begin
            otherErrors++;
            $display("core halted before the model reached the halt instruction");
        end
        $display("errors: %0d bus mismatches, %0d other", errorCount, otherErrors);
        if (errorCount == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (resetCycles + 2 + timeoutCycles) @(posedge iClk);
        $display("timeout: core did not halt within %0d cycles", timeoutCycles);
        $display("errors: %0d bus mismatches, %0d other", errorCount, otherErrors + 1);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== sources.f ====
common/coreDefs.sv
common/regPortIf.sv
source/regFile.sv
control/stageCtrl.sv
control/instDecode.sv
datapath/alu.sv
datapath/execUnit.sv
source/epCore.sv
verification/coreChecker.sv
verification/coreTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module coreTb -f sources.f -o coreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1
